//--- include/fft_consts.svh
// Transform size, word widths and fixed-point format, included by the packages and RTL files
`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

// Transform size
// Twiddle table in butterflySchedule is written for 8 points only
`define FFT_POINTS 8

// log2 of the transform size
// Also the number of pipeline stages, one radix-2 pass each
`define FFT_LOG_POINTS 3

// Signed input sample width
`define FFT_SAMPLE_WIDTH 12

// Internal and output word width
// Holds a full-scale sample shifted by the fractional bits,
// plus growth of log2 N bits over the passes
`define FFT_WORD_WIDTH 24

// Fractional bits of the fixed-point format
// Samples enter the pipeline scaled by 2^FFT_FRAC_BITS
`define FFT_FRAC_BITS 8

// Twiddle width
// Two bits above the fraction so that +1.0 and -1.0 both fit
`define FFT_TWIDDLE_WIDTH (`FFT_FRAC_BITS + 2)

// Butterflies in one pass
`define FFT_HALF_POINTS (`FFT_POINTS / 2)

// Counter and index widths
`define FFT_SLOT_WIDTH `FFT_LOG_POINTS
`define FFT_COUNT_WIDTH (`FFT_LOG_POINTS - 1)

// Stage number width, enough for FFT_LOG_POINTS stages
`define FFT_STAGE_WIDTH 2

`endif

//--- design/fftNumericPkg.sv
// Number types for samples, fixed-point words, twiddles and frames, imported by the datapath
`include "fft_consts.svh"

package fftNumericPkg;

	// Raw sample as it arrives from the source
	typedef logic signed [`FFT_SAMPLE_WIDTH - 1:0] sampleWord;

	// Fixed-point value
	// Low FFT_FRAC_BITS bits are the fraction
	typedef logic signed [`FFT_WORD_WIDTH - 1:0] fftWord;

	// Twiddle coefficient, same fraction as fftWord
	// Range is -1.0 to +1.0 inclusive
	typedef logic signed [`FFT_TWIDDLE_WIDTH - 1:0] twiddleWord;

	// One complete frame of N words
	// Index is the frame slot, not the sample time
	typedef fftWord fftFrame [`FFT_POINTS];

endpackage

//--- design/fftSchedulePkg.sv
// Types for butterfly scheduling (slots, stages, counters, twiddle indexes), imported by stage logic
`include "fft_consts.svh"

package fftSchedulePkg;

	// Position of a word inside a frame buffer
	typedef logic [`FFT_SLOT_WIDTH - 1:0] slotIndex;

	// Position of a stage in the chain
	// Stage s performs the pass with span 2^s
	typedef logic [`FFT_STAGE_WIDTH - 1:0] stageNumber;

	// Butterfly within one pass, 0 to N/2-1
	// Wraps to zero after the last butterfly
	typedef logic [`FFT_COUNT_WIDTH - 1:0] butterflyCount;

	// Entry of the twiddle table, 0 to N/2-1
	typedef logic [`FFT_COUNT_WIDTH - 1:0] twiddleIndex;

endpackage

//--- design/butterflyUnit.sv
// Combinational fixed-point radix-2 butterfly, one per pipeline stage
`include "fft_consts.svh"

module butterflyUnit
	import fftNumericPkg::*;
(
	input fftWord upperReal,
	input fftWord upperImag,
	input fftWord lowerReal,
	input fftWord lowerImag,
	input twiddleWord twiddleReal,
	input twiddleWord twiddleImag,
	output fftWord sumReal,
	output fftWord sumImag,
	output fftWord diffReal,
	output fftWord diffImag
);

	fftWord lowerRealScaled;
	fftWord lowerImagScaled;
	fftWord twiddleRealWide;
	fftWord twiddleImagWide;
	fftWord productReal;
	fftWord productImag;

	always_comb begin
		// Drop the fraction first so the product keeps the word's scaling
		lowerRealScaled = lowerReal >>> `FFT_FRAC_BITS;
		lowerImagScaled = lowerImag >>> `FFT_FRAC_BITS;
		// Sign-extend coefficients to the word width
		twiddleRealWide = fftWord'(twiddleReal);
		twiddleImagWide = fftWord'(twiddleImag);
		// Complex product W * lower, truncated to the word width
		productReal = twiddleRealWide * lowerRealScaled - twiddleImagWide * lowerImagScaled;
		productImag = twiddleRealWide * lowerImagScaled + twiddleImagWide * lowerRealScaled;
		// Upper slot gets a + W*b
		sumReal = upperReal + productReal;
		sumImag = upperImag + productImag;
		// Lower slot gets a - W*b
		diffReal = upperReal - productReal;
		diffImag = upperImag - productImag;
	end

endmodule

//--- design/butterflySchedule.sv
// Per-stage schedule giving slot pair and twiddle for the current butterfly, instanced in fftStage
`include "fft_consts.svh"

module butterflySchedule
	import fftNumericPkg::*, fftSchedulePkg::*;
#(
	parameter fftSchedulePkg::stageNumber stageNumber = '0
) (
	input butterflyCount count,
	output slotIndex upperSlot,
	output slotIndex lowerSlot,
	output twiddleWord twiddleReal,
	output twiddleWord twiddleImag
);

	// Distance between the two slots of a butterfly
	localparam int span = 1 << stageNumber;

	// Twiddle index is offset * N / (2 * span)
	localparam int twiddleShift = `FFT_LOG_POINTS - 1 - stageNumber;

	butterflyCount offset;
	slotIndex groupBase;
	twiddleIndex tableEntry;

	// Slot pair for butterfly count
	always_comb begin
		// Position inside the group
		offset = count & butterflyCount'(span - 1);
		// Each group covers twice the span
		groupBase = slotIndex'(count >> stageNumber) << (stageNumber + 1);
		upperSlot = groupBase + slotIndex'(offset);
		lowerSlot = upperSlot + slotIndex'(span);
		tableEntry = twiddleIndex'(offset << twiddleShift);
	end

	// W^k = cos(2*pi*k/N) - j*sin(2*pi*k/N)
	// Scaled by 2^FFT_FRAC_BITS, truncated toward zero
	// Written for N = 8 with 8 fraction bits
	always_comb begin
		case (tableEntry)
			2'd0: begin
				twiddleReal = 10'sd256;
				twiddleImag = 10'sd0;
			end
			2'd1: begin
				twiddleReal = 10'sd181;
				twiddleImag = -10'sd181;
			end
			2'd2: begin
				twiddleReal = 10'sd0;
				twiddleImag = -10'sd256;
			end
			default: begin
				twiddleReal = -10'sd181;
				twiddleImag = -10'sd181;
			end
		endcase
	end

endmodule

//--- design/sampleWindow.sv
// Sliding window of the N newest samples, offered to the first stage as a bit-reversed frame
`include "fft_consts.svh"

module sampleWindow
	import fftNumericPkg::*, fftSchedulePkg::*;
(
	input logic advanceSignal,
	input logic reset,
	input sampleWord sampleIn,
	input logic sampleStrobe,
	input logic stageIdle,
	output fftFrame frameIn,
	output logic frameOffered
);

	// Slot 0 holds the newest sample
	// Slot n is sample n of the transform
	sampleWord window [`FFT_POINTS];

	// Mirror the slot number bit by bit
	function automatic slotIndex reverseBits(input slotIndex position);
		slotIndex reversed;
		for (int b = 0; b < `FFT_LOG_POINTS; b++) begin
			reversed[b] = position[`FFT_LOG_POINTS - 1 - b];
		end
		return reversed;
	endfunction

	// Shift on every strobe
	always_ff @(posedge advanceSignal) begin
		if (reset) begin
			window <= '{default: '0};
		end else if (sampleStrobe) begin
			// Newest sample enters at slot 0
			window[0] <= sampleIn;
			// Older samples move one slot up, oldest drops out
			for (int n = 1; n < `FFT_POINTS; n++) begin
				window[n] <= window[n - 1];
			end
		end
	end

	// Frame always shows the current window
	// A frame held back by a busy stage is therefore taken with the newest samples
	always_comb begin
		for (int n = 0; n < `FFT_POINTS; n++) begin
			// Sign-extend and scale into the fixed-point format
			frameIn[reverseBits(slotIndex'(n))] = fftWord'(window[n]) <<< `FFT_FRAC_BITS;
		end
	end

	// Request flag for stage 0
	// Set after a strobe, cleared once the stage has taken the frame
	always_ff @(posedge advanceSignal) begin
		if (reset) begin
			frameOffered <= 1'b0;
		end else if (sampleStrobe) begin
			// New window wins over a transfer in the same cycle
			frameOffered <= 1'b1;
		end else if (stageIdle) begin
			// Idle stage loads whatever is offered this cycle
			frameOffered <= 1'b0;
		end
	end

	// Several strobes during a busy stage merge into one offer
	// Only the window at transfer time gets transformed

endmodule

//--- design/fftStage.sv
// One radix-2 pass over a buffered frame, N/2 butterflies at one per cycle, chained by fftPipeline
`include "fft_consts.svh"

module fftStage
	import fftNumericPkg::*, fftSchedulePkg::*;
#(
	parameter fftSchedulePkg::stageNumber stageNumber = '0
) (
	input logic advanceSignal,
	input logic reset,
	input fftFrame frameIn,
	input fftFrame frameInImag,
	input logic inputReady,
	input logic nextIdle,
	output fftFrame frameOut,
	output fftFrame frameOutImag,
	output logic stageIdle,
	output logic resultReady
);

	// Frame being worked on, later the finished result
	fftFrame realBuffer;
	fftFrame imagBuffer;

	logic busy;
	butterflyCount butterflyCounter;

	// Current butterfly
	slotIndex upperSlot;
	slotIndex lowerSlot;
	twiddleWord twiddleReal;
	twiddleWord twiddleImag;
	fftWord sumReal;
	fftWord sumImag;
	fftWord diffReal;
	fftWord diffImag;

	butterflySchedule #(.stageNumber(stageNumber)) schedule (
		.count(butterflyCounter),
		.upperSlot(upperSlot),
		.lowerSlot(lowerSlot),
		.twiddleReal(twiddleReal),
		.twiddleImag(twiddleImag)
	);

	// Reads both slots straight from the buffers
	butterflyUnit butterfly (
		.upperReal(realBuffer[upperSlot]),
		.upperImag(imagBuffer[upperSlot]),
		.lowerReal(realBuffer[lowerSlot]),
		.lowerImag(imagBuffer[lowerSlot]),
		.twiddleReal(twiddleReal),
		.twiddleImag(twiddleImag),
		.sumReal(sumReal),
		.sumImag(sumImag),
		.diffReal(diffReal),
		.diffImag(diffImag)
	);

	// Neither computing nor holding a result
	assign stageIdle = !busy && !resultReady;
	assign frameOut = realBuffer;
	assign frameOutImag = imagBuffer;

	always_ff @(posedge advanceSignal) begin
		if (reset) begin
			busy <= 1'b0;
			resultReady <= 1'b0;
			butterflyCounter <= '0;
			realBuffer <= '{default: '0};
			imagBuffer <= '{default: '0};
		end else if (stageIdle && inputReady) begin
			// Transfer cycle, take the upstream frame
			realBuffer <= frameIn;
			imagBuffer <= frameInImag;
			butterflyCounter <= '0;
			busy <= 1'b1;
		end else if (busy) begin
			// In-place update of both slots
			realBuffer[upperSlot] <= sumReal;
			imagBuffer[upperSlot] <= sumImag;
			realBuffer[lowerSlot] <= diffReal;
			imagBuffer[lowerSlot] <= diffImag;
			butterflyCounter <= butterflyCounter + 1'b1;
			// Result offered the cycle after the last butterfly
			if (butterflyCounter == butterflyCount'(`FFT_HALF_POINTS - 1)) begin
				busy <= 1'b0;
				resultReady <= 1'b1;
			end
		end else if (resultReady && nextIdle) begin
			// Downstream loads this cycle
			resultReady <= 1'b0;
		end
	end

endmodule

//--- design/fftPipeline.sv
// Top level of the streaming FFT, joining the sample window to the chain of radix-2 stages
`include "fft_consts.svh"

module fftPipeline
	import fftNumericPkg::*, fftSchedulePkg::*;
(
	input logic advanceSignal,
	input logic reset,
	input sampleWord sampleIn,
	input logic sampleStrobe,
	output fftFrame binReal,
	output logic outputValid
);

	// Chain links
	// Link s feeds stage s, link s+1 is its result
	fftFrame chainReal [`FFT_LOG_POINTS + 1];
	fftFrame chainImag [`FFT_LOG_POINTS + 1];
	logic chainReady [`FFT_LOG_POINTS + 1];
	// Idle of stage s, last entry stands for the output side
	logic chainIdle [`FFT_LOG_POINTS + 1];

	sampleWindow window (
		.advanceSignal(advanceSignal),
		.reset(reset),
		.sampleIn(sampleIn),
		.sampleStrobe(sampleStrobe),
		.stageIdle(chainIdle[0]),
		.frameIn(chainReal[0]),
		.frameOffered(chainReady[0])
	);

	// Real input samples only
	assign chainImag[0] = '{default: '0};

	for (genvar s = 0; s < `FFT_LOG_POINTS; s++) begin : stageChain
		fftStage #(.stageNumber(stageNumber'(s))) stage (
			.advanceSignal(advanceSignal),
			.reset(reset),
			.frameIn(chainReal[s]),
			.frameInImag(chainImag[s]),
			.inputReady(chainReady[s]),
			.nextIdle(chainIdle[s + 1]),
			.frameOut(chainReal[s + 1]),
			.frameOutImag(chainImag[s + 1]),
			.stageIdle(chainIdle[s]),
			.resultReady(chainReady[s + 1])
		);
	end

	// Output always accepts, so the last result flag lasts one cycle
	assign chainIdle[`FFT_LOG_POINTS] = 1'b1;

	// Real parts only
	assign binReal = chainReal[`FFT_LOG_POINTS];
	assign outputValid = chainReady[`FFT_LOG_POINTS];

endmodule

//--- sim/clockGen.sv
// Testbench clock and synchronous reset source, instanced by the fftPipeline testbench
module clockGen #(
	parameter int halfPeriod = 10,
	parameter int resetCycles = 5
) (
	output logic advanceSignal,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	// Free-running clock, starts low
	initial begin
		advanceSignal = 1'b0;
		forever #halfPeriod advanceSignal = ~advanceSignal;
	end

	// Reset seen by resetCycles rising edges
	// Released on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge advanceSignal);
		@(negedge advanceSignal);
		reset = 1'b0;
	end

endmodule

//--- sim/fftPipelineTb.sv
// Testbench for fftPipeline, replays sim/fft_stim.txt and checks each settled transform
`include "fft_consts.svh"

module fftPipelineTb
	import fftNumericPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int stimDepth = 128;
	localparam int resetCycles = 5;
	localparam int idleCycles = 20;
	// Quiet stretch after which no frame can still be in flight
	localparam int drainCycles = 2 * `FFT_LOG_POINTS * (`FFT_HALF_POINTS + 2);
	// Cycle budget per stimulus word
	localparam int cyclesPerEntry = `FFT_LOG_POINTS * (`FFT_HALF_POINTS + 1) + 8;

	logic advanceSignal;
	logic reset;
	sampleWord sampleIn;
	logic sampleStrobe;
	fftFrame binReal;
	logic outputValid;

	logic [31:0] stimulus [stimDepth];
	int entryCount;
	bit stimLoaded;
	integer seed;
	int errorCount;
	int testErrors;
	int testCount;
	// Activity since the last check
	int strobesSent;
	int pulsesSeen;
	bit pulseThisCycle;
	fftFrame lastFrame;
	// Expected bins of the current test, zero unless listed
	int expected [`FFT_POINTS];

	clockGen #(.halfPeriod(10), .resetCycles(resetCycles)) clocks (
		.advanceSignal(advanceSignal),
		.reset(reset)
	);

	fftPipeline i_fftPipeline (
		.advanceSignal(advanceSignal),
		.reset(reset),
		.sampleIn(sampleIn),
		.sampleStrobe(sampleStrobe),
		.binReal(binReal),
		.outputValid(outputValid)
	);

	task automatic compareValue(input string name, input logic signed [31:0] actual,
			input logic signed [31:0] expectedValue);
		if (actual !== expectedValue) begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual,
				expectedValue);
			errorCount++;
			testErrors++;
		end
	endtask

	// One cycle, outputs read on the falling edge before inputs change
	task automatic advanceCycle();
		@(negedge advanceSignal);
		pulseThisCycle = outputValid;
		if (outputValid) begin
			pulsesSeen++;
			lastFrame = binReal;
		end
		sampleStrobe = 1'b0;
	endtask

	// Strobe lands on the rising edge after the drive
	task automatic sendSample(input sampleWord value, input int gap);
		repeat (gap) advanceCycle();
		advanceCycle();
		sampleIn = value;
		sampleStrobe = 1'b1;
		strobesSent++;
	endtask

	task automatic finishTest(input int testNumber);
		if (testErrors == 0) begin
			$display("Test %0d: ok", testNumber);
		end else begin
			$display("Test %0d: %0d errors", testNumber, testErrors);
		end
		testCount++;
		testErrors = 0;
		strobesSent = 0;
		pulsesSeen = 0;
		expected = '{default: 0};
	endtask

	// Nothing moves until the first strobe
	task automatic checkIdleAfterReset();
		repeat (idleCycles) begin
			advanceCycle();
			compareValue("outputValid", 32'(outputValid), 0);
			for (int k = 0; k < `FFT_POINTS; k++) begin
				compareValue($sformatf("binReal[%0d]", k), 32'(binReal[k]), 0);
			end
		end
		finishTest(1);
	endtask

	// Wait until outputValid has gone quiet, then check the last frame delivered
	task automatic settleAndCheck(input int testNumber);
		int quiet;
		quiet = 0;
		while (quiet < drainCycles) begin
			advanceCycle();
			if (pulseThisCycle) begin
				quiet = 0;
			end else begin
				quiet++;
			end
		end
		// Merged frames give at most one pulse per strobe
		if (pulsesSeen < 1 || pulsesSeen > strobesSent) begin
			$display("Test %0d saw %0d outputValid pulses after %0d strobes", testNumber,
				pulsesSeen, strobesSent);
			errorCount++;
			testErrors++;
		end
		for (int k = 0; k < `FFT_POINTS; k++) begin
			compareValue($sformatf("binReal[%0d]", k), 32'(lastFrame[k]), expected[k]);
		end
		finishTest(testNumber);
	endtask

	// Op in the top digit, index in the next, 24-bit value below
	task automatic runEntry(input logic [31:0] entry);
		logic [3:0] op;
		logic [3:0] index;
		fftWord value;
		op = entry[31:28];
		index = entry[27:24];
		value = entry[23:0];
		case (op)
			4'd1: sendSample(sampleWord'(value), $unsigned($random(seed)) % 4);
			4'd2: sendSample(sampleWord'(value), 0);
			4'd3: expected[index[2:0]] = int'(value);
			4'd4: settleAndCheck(int'(index));
			default: begin
				$display("Unknown stimulus word %h", entry);
				errorCount++;
			end
		endcase
	endtask

	initial begin
		sampleIn = '0;
		sampleStrobe = 1'b0;
		seed = 32'hc647d1e7;
		errorCount = 0;
		testErrors = 0;
		testCount = 0;
		strobesSent = 0;
		pulsesSeen = 0;
		lastFrame = '{default: '0};
		expected = '{default: 0};
		stimulus = '{default: '0};
		$readmemh("sim/fft_stim.txt", stimulus);
		// Op zero marks the end of the list
		entryCount = 0;
		while (entryCount < stimDepth && stimulus[entryCount][31:28] != 4'd0) begin
			entryCount++;
		end
		if (entryCount == 0) begin
			$display("No stimulus could be read from sim/fft_stim.txt");
			errorCount++;
		end
		stimLoaded = 1'b1;
		wait (reset === 1'b0);
		checkIdleAfterReset();
		for (int position = 0; position < entryCount; position++) begin
			runEntry(stimulus[position]);
		end
		$display("%0d tests run, %0d errors", testCount, errorCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Watchdog, budget scales with the stimulus length
	initial begin
		int limit;
		wait (stimLoaded);
		limit = entryCount * cyclesPerEntry + resetCycles + idleCycles + drainCycles;
		repeat (limit) @(posedge advanceSignal);
		$display("Timeout, the run did not finish within %0d cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- sim/fft_stim.txt
// Hex words: op digit, index digit, 24-bit value. Op 1 strobes after a random gap, op 2 next cycle
// Op 3 sets expected bin <index> to <value>, op 4 settles and checks test <index>, others expect 0

// Test 2, constant 100 over eight strobes
10000064 10000064 10000064 10000064
10000064 10000064 10000064 10000064
30032000
42000000

// Test 3, impulse of 300 at the newest sample
10000000 10000000 10000000 10000000
10000000 10000000 10000000 1000012C
30012C00 31012C00 32012C00 33012C00
34012C00 35012C00 36012C00 37012C00
43000000

// Test 4, one more zero moves the impulse to sample 1
10000000
30012C00 3100D41C 33FF2BE4 34FED400
35FF2BE4 3700D41C
44000000

// Test 5, alternating +50 and -50, newest +50
10000FCE 10000032 10000FCE 10000032
10000FCE 10000032 10000FCE 10000032
34019000
45000000

// Test 6, ramp 800 down to 100 on consecutive cycles
20000320 200002BC 20000258 200001F4
20000190 2000012C 200000C8 20000064
300E1000 31FE7000 32FE7000 33FE7000
34FE7000 35FE7000 36FE7000 37FE7000
46000000

//--- project.f
+incdir+include
design/fftNumericPkg.sv
design/fftSchedulePkg.sv
design/butterflyUnit.sv
design/butterflySchedule.sv
design/sampleWindow.sv
design/fftStage.sv
design/fftPipeline.sv
sim/clockGen.sv
sim/fftPipelineTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= fftPipelineTb
FILELIST ?= project.f
LOG ?= sim.log
PASS_MSG = *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
